/* hdl/atom_pkg.sv */
/*
 * Shared constants for the Atom I/O corner
 * Address map covers only the PIA window, the ROM latch and the lock byte
 * Divider constants assume a 25 MHz clk25
 */

package atom_pkg;

   // ==============================
   // Bus widths
   // ==============================

   // Atom CPU side
   localparam int addr_w     = 16;
   localparam int data_w     = 8;
   // Host side, only the low byte carries data
   localparam int axi_data_w = 32;

   // ==============================
   // Address map
   // ==============================

   // B000-B00F, 8255 PIA (decoded on the upper 12 bits)
   localparam logic [11:0] pia_base = 12'hb00;
   // ROM bank latch
   localparam logic [15:0] rom_latch_addr = 16'hbfff;
   // Zero page byte holding the lock flag
   localparam logic [15:0] lock_addr = 16'h00e7;
   localparam int lock_bit = 5;

   // ==============================
   // Divider constants
   // ==============================

   // 25 MHz down to 1 MHz base rate
   localparam logic [4:0] clkdiv_last = 5'd24;
   // 208 bus cycles per tone half period
   localparam logic [7:0] cas_div_last = 8'd207;

   // PIA control word at register index 3
   // Bit 7 clear selects port C bit set/reset
   typedef union packed {
      struct packed {
         logic       mode_flag;
         logic [3:0] spare;
         logic [1:0] bit_sel;
         logic       bit_val;
      } bsr;
      struct packed {
         logic       mode_flag;
         logic [6:0] mode_bits;   // ports have fixed directions
      } mode_word;
   } pia_ctrl_u;

endpackage

/* hdl/cpu_clken_gen.sv */
/*
 * CPU bus-cycle enable from the 25 MHz clock
 * turbo 00 = 1 MHz, 01 = 2 MHz, 1x = 4 MHz
 * Pulses are not evenly spaced in the faster modes
 */

`timescale 1ns/1ps

module cpu_clken_gen
   import atom_pkg::*;
   (
      input  logic       clk25,
      input  logic       reset,
      input  logic [1:0] turbo,
      output logic       cpu_clken
   );

   // Free running count 0 to 24
   logic [4:0] clkdiv;
   logic       clken_next;

   always_ff @(posedge clk25 or posedge reset)
   begin
      if (reset)
      begin
         clkdiv <= '0;
      end
      else if (clkdiv == clkdiv_last)
      begin
         clkdiv <= '0;
      end
      else
      begin
         clkdiv <= clkdiv + 5'd1;
      end
   end

   // Pick the counts that fire
   // Counts 16 and up never fire
   always_comb
   begin
      case (turbo)
         2'b00:   clken_next = (clkdiv[3:0] == 4'd0) && !clkdiv[4];   // count 0
         2'b01:   clken_next = (clkdiv[2:0] == 3'd0) && !clkdiv[4];   // 0 and 8
         default: clken_next = (clkdiv[1:0] == 2'd0) && !clkdiv[4];   // 0, 4, 8, 12
      endcase
   end

   // Registered one cycle behind the count
   always_ff @(posedge clk25 or posedge reset)
   begin
      if (reset)
      begin
         cpu_clken <= 1'b0;
      end
      else
      begin
         cpu_clken <= clken_next;
      end
   end

endmodule

/* hdl/axil_bus_bridge.sv */
/*
 * AXI4-Lite slave, one transaction in flight at a time
 * Each transaction becomes one bus cycle on the next cpu_clken
 * Reads win over writes; only byte lane 0 is used, responses are always OKAY
 */

`timescale 1ns/1ps

module axil_bus_bridge
   import atom_pkg::*;
   (
      input  logic                  clk25,
      input  logic                  reset,
      // Write address and data
      input  logic                  awvalid,
      output logic                  awready,
      input  logic [addr_w-1:0]     awaddr,
      input  logic                  wvalid,
      output logic                  wready,
      input  logic [axi_data_w-1:0] wdata,
      input  logic [3:0]            wstrb,
      // Write response
      output logic                  bvalid,
      input  logic                  bready,
      output logic [1:0]            bresp,
      // Read address and data
      input  logic                  arvalid,
      output logic                  arready,
      input  logic [addr_w-1:0]     araddr,
      output logic                  rvalid,
      input  logic                  rready,
      output logic [axi_data_w-1:0] rdata,
      output logic [1:0]            rresp,
      // Atom bus side
      input  logic                  cpu_clken,
      output logic                  bus_en,
      output logic                  bus_we,
      output logic [addr_w-1:0]     bus_addr,
      output logic [data_w-1:0]     bus_wdata,
      input  logic [data_w-1:0]     bus_rdata
   );

   logic              pend;         // accepted, waiting for the bus cycle
   logic              pend_write;
   logic              pend_we;      // write with byte lane 0 enabled
   logic [addr_w-1:0] addr_q;
   logic [data_w-1:0] wdata_q;
   logic [data_w-1:0] rdata_q;
   logic              idle;
   logic              rd_hs;
   logic              wr_hs;

   // Nothing pending, no response out, no ready already offered
   assign idle  = !pend && !bvalid && !rvalid && !arready && !awready;
   assign rd_hs = arvalid && arready;
   assign wr_hs = awvalid && awready && wvalid && wready;

   // ==============================
   // Handshake and response control
   // ==============================

   always_ff @(posedge clk25 or posedge reset)
   begin
      if (reset)
      begin
         arready    <= 1'b0;
         awready    <= 1'b0;
         wready     <= 1'b0;
         pend       <= 1'b0;
         pend_write <= 1'b0;
         pend_we    <= 1'b0;
         bvalid     <= 1'b0;
         rvalid     <= 1'b0;
      end
      else
      begin
         // Readies are single-cycle pulses
         arready <= 1'b0;
         awready <= 1'b0;
         wready  <= 1'b0;
         if (idle)
         begin
            if (arvalid)
            begin
               arready <= 1'b1;
            end
            else if (awvalid && wvalid)
            begin
               awready <= 1'b1;
               wready  <= 1'b1;
            end
         end
         if (rd_hs)
         begin
            pend       <= 1'b1;
            pend_write <= 1'b0;
            pend_we    <= 1'b0;
         end
         else if (wr_hs)
         begin
            pend       <= 1'b1;
            pend_write <= 1'b1;
            pend_we    <= wstrb[0];
         end
         // Bus cycle done, raise the matching response
         if (bus_en)
         begin
            pend <= 1'b0;
            if (pend_write)
               bvalid <= 1'b1;
            else
               rvalid <= 1'b1;
         end
         if (bvalid && bready)
            bvalid <= 1'b0;
         if (rvalid && rready)
            rvalid <= 1'b0;
      end
   end

   // Captured address, data and read result
   always_ff @(posedge clk25)
   begin
      if (rd_hs)
      begin
         addr_q <= araddr;
      end
      else if (wr_hs)
      begin
         addr_q  <= awaddr;
         wdata_q <= wdata[data_w-1:0];
      end
      if (bus_en && !pend_write)
         rdata_q <= bus_rdata;
   end

   // One bus cycle per accepted transaction
   assign bus_en    = pend && cpu_clken;
   assign bus_we    = pend_we;
   assign bus_addr  = addr_q;
   assign bus_wdata = wdata_q;

   assign rdata = {{(axi_data_w-data_w){1'b0}}, rdata_q};
   assign bresp = 2'b00;
   assign rresp = 2'b00;

endmodule

/* hdl/atom_pia.sv */
/*
 * Minimal 8255 with fixed port directions
 * Port A output, port B input, port C low nibble output and high nibble input
 * No mode support; mode control words are ignored
 */

`timescale 1ns/1ps

module atom_pia
   import atom_pkg::*;
   (
      input  logic              clk25,
      input  logic              reset,
      input  logic              pia_sel,
      input  logic              pia_we,
      input  logic [1:0]        pia_reg,
      input  logic [data_w-1:0] pia_wdata,
      output logic [data_w-1:0] pia_rdata,
      // Port B sources
      input  logic [5:0]        keyout,
      input  logic              shift_n,
      input  logic              ctrl_n,
      // Port C high nibble sources
      input  logic              rept_n,
      input  logic              fs_n,
      input  logic              cas_in,
      input  logic              cas_tone,
      output logic [7:0]        pia_pa,
      output logic [3:0]        pia_pc_out
   );

   pia_ctrl_u ctrl_word;
   logic [7:0] port_b;
   logic [7:0] port_c;

   assign ctrl_word = pia_wdata;

   // ==============================
   // Port registers
   // ==============================

   always_ff @(posedge clk25 or posedge reset)
   begin
      if (reset)
      begin
         pia_pa     <= '0;
         pia_pc_out <= '0;
      end
      else if (pia_sel && pia_we)
      begin
         case (pia_reg)
            2'd0: pia_pa <= pia_wdata;
            2'd2: pia_pc_out <= pia_wdata[3:0];
            2'd3:
            begin
               // Bit set/reset on one of PC0..PC3
               if (!ctrl_word.mode_word.mode_flag)
                  pia_pc_out[ctrl_word.bsr.bit_sel] <= ctrl_word.bsr.bit_val;
            end
            default: ;   // port B is input only
         endcase
      end
   end

   // Keyboard column and modifier keys
   assign port_b = {shift_n, ctrl_n, keyout};
   // Upper nibble straight from the pins
   assign port_c = {fs_n, rept_n, cas_in, cas_tone, pia_pc_out};

   // Readback
   always_comb
   begin
      case (pia_reg)
         2'd0:    pia_rdata = pia_pa;
         2'd1:    pia_rdata = port_b;
         2'd2:    pia_rdata = port_c;
         default: pia_rdata = '0;   // control reg reads as zero
      endcase
   end

endmodule

/* hdl/atom_io_space.sv */
/*
 * Atom I/O decode: PIA at B000-B00F, ROM latch at BFFF, lock snoop at 00E7
 * PIA is mirrored every 4 bytes inside its window
 * 00E7 is write-only here, all unmapped reads return zero
 */

`timescale 1ns/1ps

module atom_io_space
   import atom_pkg::*;
   (
      input  logic              clk25,
      input  logic              reset,
      // Bus cycle from the bridge
      input  logic              bus_en,
      input  logic              bus_we,
      input  logic [addr_w-1:0] bus_addr,
      input  logic [data_w-1:0] bus_wdata,
      output logic [data_w-1:0] bus_rdata,
      // Keyboard and misc port inputs
      input  logic [5:0]        keyout,
      input  logic              shift_n,
      input  logic              ctrl_n,
      input  logic              rept_n,
      input  logic              fs_n,
      input  logic              cas_in,
      input  logic              cas_tone,
      // Outputs
      output logic [7:0]        pia_pa,
      output logic [3:0]        pia_pc_out,
      output logic [2:0]        rom_bank,
      output logic              lock
   );

   logic              pia_cs;
   logic              rom_latch_cs;
   logic              lock_cs;
   logic              wr_en;
   logic [data_w-1:0] rom_latch;
   logic [data_w-1:0] pia_rdata;

   // ==============================
   // Address decode
   // ==============================

   assign pia_cs       = (bus_addr[15:4] == pia_base);
   assign rom_latch_cs = (bus_addr == rom_latch_addr);
   assign lock_cs      = (bus_addr == lock_addr);
   assign wr_en        = bus_en && bus_we;

   // Full byte kept, bank select is the low 3 bits
   always_ff @(posedge clk25 or posedge reset)
   begin
      if (reset)
         rom_latch <= '0;
      else if (wr_en && rom_latch_cs)
         rom_latch <= bus_wdata;
   end

   assign rom_bank = rom_latch[2:0];

   // Lock flag snooped from writes to the zero page byte
   always_ff @(posedge clk25 or posedge reset)
   begin
      if (reset)
         lock <= 1'b0;
      else if (wr_en && lock_cs)
         lock <= bus_wdata[lock_bit];
   end

   atom_pia i_pia (
      .clk25      (clk25),
      .reset      (reset),
      .pia_sel    (bus_en && pia_cs),
      .pia_we     (bus_we),
      .pia_reg    (bus_addr[1:0]),
      .pia_wdata  (bus_wdata),
      .pia_rdata  (pia_rdata),
      .keyout     (keyout),
      .shift_n    (shift_n),
      .ctrl_n     (ctrl_n),
      .rept_n     (rept_n),
      .fs_n       (fs_n),
      .cas_in     (cas_in),
      .cas_tone   (cas_tone),
      .pia_pa     (pia_pa),
      .pia_pc_out (pia_pc_out)
   );

   // Read mux, PIA has priority
   always_comb
   begin
      if (pia_cs)
         bus_rdata = pia_rdata;
      else if (rom_latch_cs)
         bus_rdata = rom_latch;
      else
         bus_rdata = '0;
   end

endmodule

/* hdl/cassette_sound.sv */
/*
 * Cassette tone and audio
 * Tone period is 416 bus cycles, about 2.4 kHz at 1 MHz
 * Speaker is the raw PC2 bit on all four audio lines
 */

`timescale 1ns/1ps

module cassette_sound
   import atom_pkg::*;
   (
      input  logic       clk25,
      input  logic       reset,
      input  logic       cpu_clken,
      input  logic [3:0] pia_pc_out,
      output logic       cas_tone,
      output logic       cas_out,
      output logic [3:0] audio
   );

   logic [7:0] cas_div;

   // Toggle every 208 bus cycles
   always_ff @(posedge clk25 or posedge reset)
   begin
      if (reset)
      begin
         cas_div  <= '0;
         cas_tone <= 1'b0;
      end
      else if (cpu_clken)
      begin
         if (cas_div == cas_div_last)
         begin
            cas_div  <= '0;
            cas_tone <= !cas_tone;
         end
         else
         begin
            cas_div <= cas_div + 8'd1;
         end
      end
   end

   // PC0 low forces the output high
   // PC1 gates the inverted tone otherwise
   assign cas_out = !pia_pc_out[0] || (pia_pc_out[1] && !cas_tone);

   assign audio = {4{pia_pc_out[2]}};

endmodule

/* hdl/atom_io_top.sv */
/*
 * Atom I/O corner reached over AXI4-Lite
 * 16-bit byte address, 32-bit data with only the low byte used
 */

`timescale 1ns/1ps

module atom_io_top (
   input  logic        clk25,
   input  logic        reset,
   // AXI4-Lite slave
   input  logic        awvalid,
   output logic        awready,
   input  logic [15:0] awaddr,
   input  logic        wvalid,
   output logic        wready,
   input  logic [31:0] wdata,
   input  logic [3:0]  wstrb,
   output logic        bvalid,
   input  logic        bready,
   output logic [1:0]  bresp,
   input  logic        arvalid,
   output logic        arready,
   input  logic [15:0] araddr,
   output logic        rvalid,
   input  logic        rready,
   output logic [31:0] rdata,
   output logic [1:0]  rresp,
   // Speed select
   input  logic [1:0]  turbo,
   // Keyboard and port inputs
   input  logic [5:0]  keyout,
   input  logic        shift_n,
   input  logic        ctrl_n,
   input  logic        rept_n,
   input  logic        fs_n,
   input  logic        cas_in,
   // Outputs
   output logic [7:0]  pia_pa,
   output logic [3:0]  pia_pc_out,
   output logic [2:0]  rom_bank,
   output logic        lock,
   output logic        cas_out,
   output logic [3:0]  audio
);

   logic        cpu_clken;
   logic        bus_en;
   logic        bus_we;
   logic [15:0] bus_addr;
   logic [7:0]  bus_wdata;
   logic [7:0]  bus_rdata;
   logic        cas_tone;

   cpu_clken_gen i_clken (
      .clk25     (clk25),
      .reset     (reset),
      .turbo     (turbo),
      .cpu_clken (cpu_clken)
   );

   // Input side
   axil_bus_bridge i_bridge (
      .clk25     (clk25),
      .reset     (reset),
      .awvalid   (awvalid),
      .awready   (awready),
      .awaddr    (awaddr),
      .wvalid    (wvalid),
      .wready    (wready),
      .wdata     (wdata),
      .wstrb     (wstrb),
      .bvalid    (bvalid),
      .bready    (bready),
      .bresp     (bresp),
      .arvalid   (arvalid),
      .arready   (arready),
      .araddr    (araddr),
      .rvalid    (rvalid),
      .rready    (rready),
      .rdata     (rdata),
      .rresp     (rresp),
      .cpu_clken (cpu_clken),
      .bus_en    (bus_en),
      .bus_we    (bus_we),
      .bus_addr  (bus_addr),
      .bus_wdata (bus_wdata),
      .bus_rdata (bus_rdata)
   );

   // Processing part
   atom_io_space i_io (
      .clk25      (clk25),
      .reset      (reset),
      .bus_en     (bus_en),
      .bus_we     (bus_we),
      .bus_addr   (bus_addr),
      .bus_wdata  (bus_wdata),
      .bus_rdata  (bus_rdata),
      .keyout     (keyout),
      .shift_n    (shift_n),
      .ctrl_n     (ctrl_n),
      .rept_n     (rept_n),
      .fs_n       (fs_n),
      .cas_in     (cas_in),
      .cas_tone   (cas_tone),
      .pia_pa     (pia_pa),
      .pia_pc_out (pia_pc_out),
      .rom_bank   (rom_bank),
      .lock       (lock)
   );

   // Output side
   cassette_sound i_sound (
      .clk25      (clk25),
      .reset      (reset),
      .cpu_clken  (cpu_clken),
      .pia_pc_out (pia_pc_out),
      .cas_tone   (cas_tone),
      .cas_out    (cas_out),
      .audio      (audio)
   );

endmodule

/* sim/io_checker.sv */
/*
 * Reference model and response monitor for the Atom I/O corner
 * Samples on the falling edge of clk25, away from the drive edge
 * Port C bit 4 (cassette tone) is never compared
 */

`timescale 1ns/1ps

module io_checker
   import atom_pkg::*;
   (
      input  logic        clk25,
      input  logic        reset,
      input  logic        awvalid,
      input  logic        awready,
      input  logic [15:0] awaddr,
      input  logic        wvalid,
      input  logic        wready,
      input  logic [31:0] wdata,
      input  logic [3:0]  wstrb,
      input  logic        bvalid,
      input  logic        bready,
      input  logic [1:0]  bresp,
      input  logic        arvalid,
      input  logic        arready,
      input  logic [15:0] araddr,
      input  logic        rvalid,
      input  logic        rready,
      input  logic [31:0] rdata,
      input  logic [1:0]  rresp,
      input  logic [5:0]  keyout,
      input  logic        shift_n,
      input  logic        ctrl_n,
      input  logic        rept_n,
      input  logic        fs_n,
      input  logic        cas_in,
      input  logic [7:0]  pia_pa,
      input  logic [3:0]  pia_pc_out,
      input  logic [2:0]  rom_bank,
      input  logic        lock,
      input  logic        cas_out,
      input  logic [3:0]  audio,
      output int          value_errs,
      output int          proto_errs,
      output int          pending
   );

   // Model of the DUT registers
   logic [7:0]  m_pa;
   logic [3:0]  m_pc;
   logic [7:0]  m_rom;
   logic        m_lock;
   // Accepted, not yet answered
   bit          q_read[$];
   logic [15:0] q_addr[$];
   logic [7:0]  q_data[$];
   bit          q_we[$];
   // Last sample, for the stability rules
   logic        b_prev;
   logic        bready_prev;
   logic        r_prev;
   logic        rready_prev;
   logic [31:0] rdata_prev;

   initial
   begin
      value_errs = 0;
      proto_errs = 0;
      pending    = 0;
   end

   // Which part of the map an address hits
   function automatic string test_name(logic [15:0] a);
      if (a[15:4] == pia_base)
      begin
         case (a[1:0])
            2'd0:    return "port_a";
            2'd1:    return "port_b";
            2'd2:    return "port_c";
            default: return "pia_ctrl";
         endcase
      end
      if (a == rom_latch_addr)
         return "rom_latch";
      if (a == lock_addr)
         return "lock_read";
      return "unmapped";
   endfunction

   // Read value from the model, tone bit left as zero
   function automatic logic [7:0] expected_read(logic [15:0] a);
      if (a[15:4] == pia_base)
      begin
         case (a[1:0])
            2'd0:    return m_pa;
            2'd1:    return {shift_n, ctrl_n, keyout};
            2'd2:    return {fs_n, rept_n, cas_in, 1'b0, m_pc};
            default: return 8'h00;
         endcase
      end
      if (a == rom_latch_addr)
         return m_rom;
      return 8'h00;
   endfunction

   task automatic apply_write(logic [15:0] a, logic [7:0] d, bit we);
      if (!we)
         return;
      if (a[15:4] == pia_base)
      begin
         case (a[1:0])
            2'd0: m_pa = d;
            2'd2: m_pc = d[3:0];
            2'd3:
            begin
               // Bit set/reset only with bit 7 clear
               if (!d[7])
                  m_pc[d[2:1]] = d[0];
            end
            default: ;
         endcase
      end
      else if (a == rom_latch_addr)
         m_rom = d;
      else if (a == lock_addr)
         m_lock = d[5];
   endtask

   task automatic compare_value(string name, logic [31:0] exp, logic [31:0] act);
      if (act !== exp)
      begin
         value_errs++;
         $display("ERR %s expected %h actual %h at %0t", name, exp, act, $time);
      end
   endtask

   task automatic report_protocol(string msg);
      proto_errs++;
      $display("Protocol error at %0t: %s", $time, msg);
   endtask

   task automatic drop_front();
      void'(q_read.pop_front());
      void'(q_addr.pop_front());
      void'(q_data.pop_front());
      void'(q_we.pop_front());
   endtask

   // ==============================
   // Monitor
   // ==============================

   always @(negedge clk25)
   begin
      string       name;
      logic [31:0] mask;
      if (reset)
      begin
         compare_value("reset_handshake", 32'h0, {awready, wready, arready, bvalid, rvalid});
         compare_value("reset_outputs", 32'h0, {pia_pa, pia_pc_out, rom_bank, lock});
         m_pa        = '0;
         m_pc        = '0;
         m_rom       = '0;
         m_lock      = 1'b0;
         b_prev      = 1'b0;
         bready_prev = 1'b0;
         r_prev      = 1'b0;
         rready_prev = 1'b0;
      end
      else
      begin
         // Held responses must not move
         if (b_prev && !bready_prev && !bvalid)
            report_protocol("bvalid dropped before bready");
         if (r_prev && !rready_prev && (!rvalid || rdata !== rdata_prev))
            report_protocol("rvalid or rdata changed before rready");
         if (awready !== wready)
            report_protocol("awready and wready differ");

         // New write response, registers changed on that edge
         if (bvalid && !b_prev)
         begin
            compare_value("bresp", 32'h0, bresp);
            if (q_read.size() == 0)
               report_protocol("write response with no open transaction");
            else
            begin
               if (q_read[0])
                  report_protocol("write response to a read");
               else
                  apply_write(q_addr[0], q_data[0], q_we[0]);
               drop_front();
            end
         end

         // New read response
         if (rvalid && !r_prev)
         begin
            compare_value("rresp", 32'h0, rresp);
            if (q_read.size() == 0)
               report_protocol("read response with no open transaction");
            else
            begin
               if (!q_read[0])
                  report_protocol("read response to a write");
               else
               begin
                  name = test_name(q_addr[0]);
                  mask = (name == "port_c") ? 32'hffff_ffef : 32'hffff_ffff;
                  compare_value(name, {24'h0, expected_read(q_addr[0])} & mask, rdata & mask);
               end
               drop_front();
            end
         end

         // Handshake completes on the coming edge
         if ((arvalid && arready) || (awvalid && awready && wvalid && wready))
         begin
            if (q_read.size() != 0 || bvalid || rvalid)
               report_protocol("transaction accepted while another was open");
         end
         if (arvalid && arready)
         begin
            q_read.push_back(1'b1);
            q_addr.push_back(araddr);
            q_data.push_back(8'h00);
            q_we.push_back(1'b0);
         end
         else if (awvalid && awready && wvalid && wready)
         begin
            q_read.push_back(1'b0);
            q_addr.push_back(awaddr);
            q_data.push_back(wdata[7:0]);
            q_we.push_back(wstrb[0]);
         end

         // Output pins against the model
         compare_value("pia_pa", m_pa, pia_pa);
         compare_value("pia_pc_out", m_pc, pia_pc_out);
         compare_value("rom_bank", m_rom[2:0], rom_bank);
         compare_value("lock", m_lock, lock);
         compare_value("audio", {4{m_pc[2]}}, audio);
         // Tone only matters with PC0 and PC1 both high
         if (!m_pc[0])
            compare_value("cas_out", 32'h1, cas_out);
         else if (!m_pc[1])
            compare_value("cas_out", 32'h0, cas_out);

         b_prev      = bvalid;
         bready_prev = bready;
         r_prev      = rvalid;
         rready_prev = rready;
         rdata_prev  = rdata;
      end
      pending = q_read.size();
   end

endmodule

/* sim/tb_atom_io.sv */
/*
 * Random AXI4-Lite traffic into the Atom I/O corner
 * Next request is offered while the last response may still be held
 * Keyboard and turbo inputs only change once the last response has arrived
 */

`timescale 1ns/1ps

module tb_atom_io;

   localparam int clk_period       = 40;
   localparam int num_trans        = 400;
   localparam int cycles_per_trans = 60;

   logic        clk25;
   logic        reset;
   logic        awvalid;
   logic        awready;
   logic [15:0] awaddr;
   logic        wvalid;
   logic        wready;
   logic [31:0] wdata;
   logic [3:0]  wstrb;
   logic        bvalid;
   logic        bready;
   logic [1:0]  bresp;
   logic        arvalid;
   logic        arready;
   logic [15:0] araddr;
   logic        rvalid;
   logic        rready;
   logic [31:0] rdata;
   logic [1:0]  rresp;
   logic [1:0]  turbo;
   logic [5:0]  keyout;
   logic        shift_n;
   logic        ctrl_n;
   logic        rept_n;
   logic        fs_n;
   logic        cas_in;
   logic [7:0]  pia_pa;
   logic [3:0]  pia_pc_out;
   logic [2:0]  rom_bank;
   logic        lock;
   logic        cas_out;
   logic [3:0]  audio;
   // Error counts from the checker
   int          value_errs;
   int          proto_errs;
   int          pending;
   int          drain_errs;

   atom_io_top i_dut (.*);

   io_checker i_checker (.*);

   initial
   begin
      clk25 = 1'b0;
      forever #(clk_period / 2) clk25 = ~clk25;
   end

   // Watchdog, 60 cycles per transaction on average
   initial
   begin
      #(num_trans * cycles_per_trans * clk_period);
      $display("Watchdog expired before all transactions completed");
      $display("Some tests failed");
      $finish;
   end

   // Mostly PIA window with mirrors, then BFFF, 00E7, anything
   function automatic logic [15:0] pick_address();
      logic [3:0] low;
      low = $urandom;
      case ($urandom_range(0, 9))
         0, 1, 2, 3, 4, 5: return {12'hb00, low};
         6, 7:             return 16'hbfff;
         8:                return 16'h00e7;
         default:          return $urandom;
      endcase
   endfunction

   task automatic shuffle_inputs();
      @(posedge clk25);
      turbo   <= $urandom_range(0, 3);
      keyout  <= $urandom;
      shift_n <= $urandom_range(0, 1);
      ctrl_n  <= $urandom_range(0, 1);
      rept_n  <= $urandom_range(0, 1);
      fs_n    <= $urandom_range(0, 1);
      cas_in  <= $urandom_range(0, 1);
   endtask

   // Random ready until the response is taken
   task automatic collect_response(input bit is_read);
      bit done;
      done = 1'b0;
      while (!done)
      begin
         @(posedge clk25);
         if (is_read)
            rready <= $urandom_range(0, 1);
         else
            bready <= $urandom_range(0, 1);
         @(negedge clk25);
         done = is_read ? (rvalid && rready) : (bvalid && bready);
      end
      @(posedge clk25);
      rready <= 1'b0;
      bready <= 1'b0;
   endtask

   // Until the open transaction shows its response
   task automatic wait_response(input bit is_read);
      do
         @(negedge clk25);
      while (is_read ? !rvalid : !bvalid);
   endtask

   // Address phase only
   task automatic issue_read(input logic [15:0] addr);
      @(posedge clk25);
      arvalid <= 1'b1;
      araddr  <= addr;
      do
         @(negedge clk25);
      while (!arready);
      @(posedge clk25);
      arvalid <= 1'b0;
   endtask

   task automatic issue_write(input logic [15:0] addr, input logic [31:0] data,
                              input logic [3:0] strobe);
      @(posedge clk25);
      awvalid <= 1'b1;
      awaddr  <= addr;
      wvalid  <= 1'b1;
      wdata   <= data;
      wstrb   <= strobe;
      do
         @(negedge clk25);
      while (!awready);
      @(posedge clk25);
      awvalid <= 1'b0;
      wvalid  <= 1'b0;
   endtask

   // ==============================
   // Stimulus
   // ==============================

   initial
   begin
      logic [15:0] addr;
      logic [31:0] data;
      logic [3:0]  strobe;
      bit          is_read;
      bit          last_read;
      void'($urandom(32'h16ab_73eb));
      drain_errs = 0;
      last_read  = 1'b0;
      reset      <= 1'b1;
      awvalid    <= 1'b0;
      awaddr     <= '0;
      wvalid     <= 1'b0;
      wdata      <= '0;
      wstrb      <= '0;
      bready     <= 1'b0;
      arvalid    <= 1'b0;
      araddr     <= '0;
      rready     <= 1'b0;
      turbo      <= 2'b00;
      keyout     <= '1;
      shift_n    <= 1'b1;
      ctrl_n     <= 1'b1;
      rept_n     <= 1'b1;
      fs_n       <= 1'b1;
      cas_in     <= 1'b0;
      repeat (4) @(posedge clk25);
      reset <= 1'b0;

      for (int n = 0; n < num_trans; n++)
      begin
         addr    = pick_address();
         data    = $urandom;
         is_read = $urandom_range(0, 1);
         // Now and then a write with byte lane 0 off
         strobe  = ($urandom_range(0, 7) == 0) ? 4'he : 4'hf;
         fork
            if (n > 0)
               collect_response(last_read);
            begin
               // Request goes out while the last response may be held back
               if (n > 0)
                  wait_response(last_read);
               shuffle_inputs();
               if (is_read)
                  issue_read(addr);
               else
                  issue_write(addr, data, strobe);
            end
         join
         last_read = is_read;
      end
      collect_response(last_read);

      repeat (4) @(posedge clk25);
      if (pending != 0)
      begin
         drain_errs++;
         $display("A transaction was accepted but never answered");
      end
      $display("Errors: value %0d, protocol %0d, end of run %0d",
               value_errs, proto_errs, drain_errs);
      if (value_errs + proto_errs + drain_errs == 0)
         $display("All tests passed");
      else
         $display("Some tests failed");
      $finish;
   end

endmodule

/* project.f */
hdl/atom_pkg.sv
hdl/cpu_clken_gen.sv
hdl/axil_bus_bridge.sv
hdl/atom_pia.sv
hdl/atom_io_space.sv
hdl/cassette_sound.sv
hdl/atom_io_top.sv
sim/io_checker.sv
sim/tb_atom_io.sv
